// File: backend_pkg.sv
package backend_pkg;

    // Physical register index and data widths are fixed so the packed structs have a known size
    localparam int PRF_ADDR_W = 6;
    localparam int NUM_PREGS  = 1 << PRF_ADDR_W;
    localparam int XLEN       = 32;

    // Shift amounts use only the low bits of the second operand
    localparam int SHAMT_W    = 5;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SLT  = 4'd7,
        OP_ADDI = 4'd8,
        OP_XORI = 4'd9
    } alu_op_t;

    typedef struct packed {
        logic                  valid;
        alu_op_t               op;
        logic [PRF_ADDR_W-1:0] rs1_phy;
        logic [PRF_ADDR_W-1:0] rs2_phy;
        logic [PRF_ADDR_W-1:0] rd_phy;
        logic [XLEN-1:0]       imm;
    } issue_pkt_t;

    typedef struct packed {
        logic                  valid;
        alu_op_t               op;
        logic [PRF_ADDR_W-1:0] rd_phy;
        logic [XLEN-1:0]       src_a;
        logic [XLEN-1:0]       src_b;
    } exec_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic [PRF_ADDR_W-1:0] rd_phy;
        logic [XLEN-1:0]       rd_value;
    } cdb_entry_t;

    // True when the opcode takes the immediate in place of rs2
    function automatic logic uses_imm(input alu_op_t op);
        return (op == OP_ADDI) || (op == OP_XORI);
    endfunction

endpackage

// File: backend_top.sv
module backend_top
    import backend_pkg::*;
#(
    parameter int LANES = 2
) (
    input  logic       clk,
    input  logic       rst_n,

    input  issue_pkt_t issue [LANES],

    output cdb_entry_t cdb   [LANES]
);

    logic [PRF_ADDR_W-1:0] rs1_idx [LANES];
    logic [PRF_ADDR_W-1:0] rs2_idx [LANES];
    logic [XLEN-1:0]       rs1_val [LANES];
    logic [XLEN-1:0]       rs2_val [LANES];
    exec_pkt_t             xpkt    [LANES];

    phys_reg_file #(
        .LANES   (LANES)
    ) u_prf (
        .clk     (clk),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .cdb     (cdb)
    );

    operand_fetch #(
        .LANES   (LANES)
    ) u_opf (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue   (issue),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .xpkt    (xpkt)
    );

    // The CDB goes out of the top and also writes back into the register file
    exec_stage #(
        .LANES   (LANES)
    ) u_exe (
        .clk     (clk),
        .rst_n   (rst_n),
        .xpkt    (xpkt),
        .cdb     (cdb)
    );

endmodule

// File: exec_stage.sv
module exec_stage
    import backend_pkg::*;
#(
    parameter int LANES = 2
) (
    input  logic       clk,
    input  logic       rst_n,

    input  exec_pkt_t  xpkt [LANES],

    output cdb_entry_t cdb  [LANES]
);

    logic [XLEN-1:0] alu_out [LANES];

    function automatic logic [XLEN-1:0] alu(
        input alu_op_t         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic [SHAMT_W-1:0] shamt;
        logic [XLEN-1:0]    result;
        shamt = b[SHAMT_W-1:0];
        case (op)
            OP_ADD,
            OP_ADDI: begin
                result = a + b;
            end
            OP_SUB: begin
                result = a - b;
            end
            OP_AND: begin
                result = a & b;
            end
            OP_OR: begin
                result = a | b;
            end
            OP_XOR,
            OP_XORI: begin
                result = a ^ b;
            end
            OP_SLL: begin
                result = a << shamt;
            end
            OP_SRL: begin
                result = a >> shamt;
            end
            OP_SLT: begin
                // Signed compare giving 1 or 0
                result = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
            end
            default: begin
                result = '0;
            end
        endcase
        return result;
    endfunction

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            alu_out[i] = alu(xpkt[i].op, xpkt[i].src_a, xpkt[i].src_b);
        end
    end

    // Result register feeding the CDB
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (!rst_n) begin
                cdb[i].valid <= 1'b0;
            end else begin
                cdb[i].valid <= xpkt[i].valid;
            end
            cdb[i].rd_phy   <= xpkt[i].rd_phy;
            cdb[i].rd_value <= alu_out[i];
        end
    end

    // An opcode outside the enum would slip through the ALU as a silent zero
    for (genvar i = 0; i < LANES; i++) begin : g_op_chk
        a_op_defined: assert property (@(posedge clk) disable iff (!rst_n)
            xpkt[i].valid |-> (xpkt[i].op inside {
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                OP_SLL, OP_SRL, OP_SLT, OP_ADDI, OP_XORI
            }))
            else $error("Lane %0d carries undefined opcode %0d", i, xpkt[i].op);
    end

endmodule

// File: operand_fetch.sv
module operand_fetch
    import backend_pkg::*;
#(
    parameter int LANES = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  issue_pkt_t            issue   [LANES],

    output logic [PRF_ADDR_W-1:0] rs1_idx [LANES],
    output logic [PRF_ADDR_W-1:0] rs2_idx [LANES],
    input  logic [XLEN-1:0]       rs1_val [LANES],
    input  logic [XLEN-1:0]       rs2_val [LANES],

    output exec_pkt_t             xpkt    [LANES]
);

    exec_pkt_t next_pkt [LANES];

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            rs1_idx[i] = issue[i].rs1_phy;
            rs2_idx[i] = issue[i].rs2_phy;
        end
    end

    // Build the execute packet, picking the immediate or the rs2 value as src_b
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            next_pkt[i].valid  = issue[i].valid;
            next_pkt[i].op     = issue[i].op;
            next_pkt[i].rd_phy = issue[i].rd_phy;
            next_pkt[i].src_a  = rs1_val[i];
            if (uses_imm(issue[i].op)) begin
                next_pkt[i].src_b = issue[i].imm;
            end else begin
                next_pkt[i].src_b = rs2_val[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (!rst_n) begin
                xpkt[i].valid <= 1'b0;
            end else begin
                xpkt[i].valid <= next_pkt[i].valid;
            end
            xpkt[i].op     <= next_pkt[i].op;
            xpkt[i].rd_phy <= next_pkt[i].rd_phy;
            xpkt[i].src_a  <= next_pkt[i].src_a;
            xpkt[i].src_b  <= next_pkt[i].src_b;
        end
    end

    // Immediate ops come from the issuing side with rs2 tied to p0, so no
    // readiness is ever implied on a second source
    for (genvar i = 0; i < LANES; i++) begin : g_imm_chk
        a_imm_no_rs2: assert property (@(posedge clk) disable iff (!rst_n)
            (issue[i].valid && uses_imm(issue[i].op)) |-> (issue[i].rs2_phy == '0))
            else $error("Lane %0d immediate op names rs2 p%0d", i, issue[i].rs2_phy);
    end

endmodule

// File: phys_reg_file.sv
module phys_reg_file
    import backend_pkg::*;
#(
    parameter int LANES = 2
) (
    input  logic                  clk,

    input  logic [PRF_ADDR_W-1:0] rs1_idx [LANES],
    input  logic [PRF_ADDR_W-1:0] rs2_idx [LANES],
    output logic [XLEN-1:0]       rs1_val [LANES],
    output logic [XLEN-1:0]       rs2_val [LANES],

    input  cdb_entry_t            cdb     [LANES]
);

    logic [XLEN-1:0] regs [NUM_PREGS];

    // Entry 0 is never written and reads of it are forced to zero below
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (cdb[i].valid && (cdb[i].rd_phy != '0)) begin
                regs[cdb[i].rd_phy] <= cdb[i].rd_value;
            end
        end
    end

    // Each read port takes storage, then a same-cycle CDB bypass, then the zero register
    function automatic logic [XLEN-1:0] read_port(input logic [PRF_ADDR_W-1:0] idx);
        logic [XLEN-1:0] value;
        value = regs[idx];
        for (int k = 0; k < LANES; k++) begin
            if (cdb[k].valid && (cdb[k].rd_phy == idx)) begin
                value = cdb[k].rd_value;
            end
        end
        if (idx == '0) begin
            value = '0;
        end
        return value;
    endfunction

    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            rs1_val[j] = read_port(rs1_idx[j]);
            rs2_val[j] = read_port(rs2_idx[j]);
        end
    end

    // The scheduler must never retire two lanes into the same register in one cycle,
    // otherwise the write and the bypass pick an arbitrary winner
    for (genvar i = 0; i < LANES; i++) begin : g_dup_a
        for (genvar j = i + 1; j < LANES; j++) begin : g_dup_b
            a_no_dup_write: assert property (@(posedge clk)
                !(cdb[i].valid && cdb[j].valid
                  && (cdb[i].rd_phy != '0)
                  && (cdb[i].rd_phy == cdb[j].rd_phy)))
                else $error("CDB lanes %0d and %0d both write p%0d", i, j, cdb[i].rd_phy);
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_backend \
    -f sources.f

# The exit status of tee is taken here, the log decides the outcome
./obj_dir/Vtb_backend | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// File: sources.f
backend_pkg.sv
phys_reg_file.sv
operand_fetch.sv
exec_stage.sv
backend_top.sv
tb_clock_gen.sv
tb_backend.sv

// File: tb_backend.sv
module tb_backend
    import backend_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LANES       = 2;
    localparam int WAIT_CYCLES = 20;
    localparam int LATENCY     = 2;

    // Values loaded into p1..p4 by the first rows of the table
    localparam logic [XLEN-1:0] BASE_VAL [4] = '{
        32'h0000_0064, 32'hFFFF_FFF6, 32'h0000_0007, 32'h8000_0001
    };

    typedef struct packed {
        int                    lane;
        alu_op_t               op;
        logic [PRF_ADDR_W-1:0] rs1;
        logic [PRF_ADDR_W-1:0] rs2;
        logic [PRF_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        int                    gap;
        logic                  same;
        logic [XLEN-1:0]       exp;
    } row_t;

    logic       clk;
    logic       rst_n;
    issue_pkt_t issue [LANES];
    cdb_entry_t cdb   [LANES];
    row_t       rows  [$];

    tb_clock_gen #(
        .HALF_PERIOD  (4),
        .RESET_CYCLES (10)
    ) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    backend_top #(
        .LANES (LANES)
    ) UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (issue),
        .cdb   (cdb)
    );

    task automatic add_row(input int lane, input alu_op_t op, input int rs1, input int rs2,
                           input int rd, input logic [XLEN-1:0] imm, input int gap,
                           input logic same, input logic [XLEN-1:0] exp);
        row_t r;
        r.lane = lane;
        r.op   = op;
        r.rs1  = PRF_ADDR_W'(rs1);
        r.rs2  = PRF_ADDR_W'(rs2);
        r.rd   = PRF_ADDR_W'(rd);
        r.imm  = imm;
        r.gap  = gap;
        r.same = same;
        r.exp  = exp;
        rows.push_back(r);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic drive_row(input row_t r);
        issue[r.lane].valid   = 1'b1;
        issue[r.lane].op      = r.op;
        issue[r.lane].rs1_phy = r.rs1;
        issue[r.lane].rs2_phy = r.rs2;
        issue[r.lane].rd_phy  = r.rd;
        issue[r.lane].imm     = r.imm;
    endtask

    task automatic clear_issue();
        for (int l = 0; l < LANES; l++) begin
            issue[l] = '0;
        end
    endtask

    // Samples on the falling edge, where the CDB registers are stable
    task automatic wait_result(input int row_idx, input int lane, output int waited);
        waited = 0;
        while (!cdb[lane].valid && (waited < WAIT_CYCLES)) begin
            @(negedge clk);
            waited++;
        end
        if (!cdb[lane].valid) begin
            $display("Timeout: row %0d produced no valid CDB result on lane %0d in %0d cycles",
                     row_idx, lane, WAIT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "No result");
        end
    endtask

    task automatic check_row(input row_t r);
        check_value($sformatf("cdb[%0d].valid", r.lane), XLEN'(cdb[r.lane].valid), 1);
        check_value($sformatf("cdb[%0d].rd_phy", r.lane), XLEN'(cdb[r.lane].rd_phy),
                    XLEN'(r.rd));
        check_value($sformatf("cdb[%0d].rd_value", r.lane), cdb[r.lane].rd_value, r.exp);
    endtask

    task automatic build_table();
        logic [XLEN-1:0] imm;
        alu_op_t         op;
        // Constants through ADDI from p0
        add_row(0, OP_ADDI, 0, 0, 1, 32'h0000_0064, 0, 0, 32'h0000_0064);
        add_row(1, OP_ADDI, 0, 0, 2, 32'hFFFF_FFF6, 0, 0, 32'hFFFF_FFF6);
        add_row(0, OP_ADDI, 0, 0, 3, 32'h0000_0007, 0, 0, 32'h0000_0007);
        add_row(1, OP_ADDI, 0, 0, 4, 32'h8000_0001, 0, 0, 32'h8000_0001);
        add_row(0, OP_ADDI, 0, 0, 5, 32'h0000_0023, 1, 0, 32'h0000_0023);
        // Register-register ops with p5 holding 35 so shifts move by 3
        add_row(1, OP_ADD, 1, 2, 10, 32'h0, 1, 0, 32'h0000_005A);
        add_row(0, OP_SUB, 1, 2, 11, 32'h0, 0, 0, 32'h0000_006E);
        add_row(1, OP_AND, 4, 2, 12, 32'h0, 0, 0, 32'h8000_0000);
        add_row(0, OP_OR, 3, 4, 13, 32'h0, 0, 0, 32'h8000_0007);
        add_row(1, OP_XOR, 4, 2, 14, 32'h0, 0, 0, 32'h7FFF_FFF7);
        add_row(0, OP_SLL, 3, 5, 15, 32'h0, 0, 0, 32'h0000_0038);
        add_row(1, OP_SRL, 4, 5, 16, 32'h0, 0, 0, 32'h1000_0000);
        add_row(0, OP_SLT, 2, 1, 17, 32'h0, 0, 0, 32'h0000_0001);
        add_row(1, OP_SLT, 1, 2, 18, 32'h0, 0, 0, 32'h0000_0000);
        add_row(0, OP_SLT, 4, 3, 19, 32'h0, 0, 0, 32'h0000_0001);
        // Gap 0 lands the consumer two cycles after its producer and gap 1 three cycles after
        add_row(1, OP_ADDI, 1, 0, 20, 32'h0000_0005, 0, 0, 32'h0000_0069);
        add_row(0, OP_ADD, 20, 3, 21, 32'h0, 0, 0, 32'h0000_0070);
        add_row(1, OP_ADDI, 3, 0, 23, 32'h0000_0010, 0, 0, 32'h0000_0017);
        add_row(0, OP_ADD, 23, 1, 24, 32'h0, 1, 0, 32'h0000_007B);
        // Writes to p0 broadcast but p0 still reads as zero even while bypassing
        add_row(1, OP_ADDI, 1, 0, 0, 32'h0000_0001, 0, 0, 32'h0000_0065);
        add_row(0, OP_ADD, 0, 3, 25, 32'h0, 0, 0, 32'h0000_0007);
        add_row(1, OP_OR, 0, 4, 26, 32'h0, 1, 0, 32'h8000_0001);
        // Both lanes in one cycle, then consumers of both results
        add_row(0, OP_ADDI, 3, 0, 27, 32'h0000_0100, 0, 0, 32'h0000_0107);
        add_row(1, OP_SUB, 1, 3, 28, 32'h0, 0, 1, 32'h0000_005D);
        add_row(0, OP_ADD, 27, 28, 29, 32'h0, 0, 0, 32'h0000_0164);
        add_row(1, OP_XOR, 27, 28, 30, 32'h0, 1, 0, 32'h0000_015A);
        // Random immediates on p1..p4
        for (int k = 0; k < 4; k++) begin
            imm = $urandom();
            op  = (k % 2 == 0) ? OP_ADDI : OP_XORI;
            if (op == OP_ADDI) begin
                add_row(k % 2, op, k + 1, 0, 40 + k, imm, 0, 0, BASE_VAL[k] + imm);
            end else begin
                add_row(k % 2, op, k + 1, 0, 40 + k, imm, 0, 0, BASE_VAL[k] ^ imm);
            end
        end
    endtask

    initial begin
        int i;
        int n;
        int waited;
        clear_issue();
        void'($urandom(32'h7d8c));
        build_table();

        for (int c = 0; (c < 50) && !rst_n; c++) begin
            @(negedge clk);
        end
        if (!rst_n) begin
            $display("Reset was never released");
            $display("Simulation FAILED");
            $fatal(1, "Reset stuck");
        end
        @(negedge clk);

        i = 0;
        while (i < rows.size()) begin
            // Rows flagged as same join the issue cycle of the row before them
            n = 1;
            while ((i + n < rows.size()) && rows[i + n].same && (n < LANES)) begin
                n++;
            end
            repeat (rows[i].gap) @(negedge clk);
            for (int k = 0; k < n; k++) begin
                drive_row(rows[i + k]);
            end
            @(negedge clk);
            clear_issue();
            wait_result(i, rows[i].lane, waited);
            // One cycle has already passed when the wait starts
            check_value($sformatf("cdb[%0d] latency in cycles", rows[i].lane),
                        XLEN'(waited + 1), XLEN'(LATENCY));
            for (int k = 0; k < n; k++) begin
                check_row(rows[i + k]);
            end
            i += n;
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule
